// ==== bench/bp_tb.sv ====
/*
 * Testbench for the branch prediction slice
 * Clock and reset, directed stimulus table, random phase against a
 * reference model of the tables and IF/ID, checks and summary
 */
`include "bp_consts.svh"

module bp_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import bp_pkg::*;

  localparam int  N_RANDOM = 200;
  localparam pc_t PC_A = 16'h0010;   // Index 8
  localparam pc_t PC_B = 16'h0024;   // Index 2
  localparam pc_t T1   = 16'h0200;
  localparam pc_t T2   = 16'h0400;
  localparam pc_t T3   = 16'h0480;

  // One cycle of stimulus plus the expected outputs
  typedef struct packed {
    logic [2:0] grp;       // Behavior number
    fetch_req_t fetch;
    resolve_t   res;       // Outcome for the IF/ID entry
    logic       stall;
    ctr_t       exp_ctr;
    pc_t        exp_tgt;
    logic       exp_rv;
    pc_t        exp_rpc;   // Checked only with exp_rv
  } row_t;

  logic       clk;
  logic       rst;
  logic       stall;
  fetch_req_t fetch;
  resolve_t   resolve;
  pred_t      pred;
  redirect_t  redirect;

  row_t   rows [$];
  string  grp_name [1:6];
  integer seed = 32'h8f6f832e;
  int     cycles;
  int     cycle_limit;
  int     pass_count;
  int     fail_count;
  int     grp_checks;
  int     grp_errs;

  ////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////

  ctr_t   m_ctr [`BP_DEPTH];   // Counter table
  pc_t    m_tgt [`BP_DEPTH];   // Target buffer
  if_id_t m_if_id;
  ctr_t   e_ctr;               // Expected outputs for this cycle
  pc_t    e_tgt;
  logic   e_rv;
  pc_t    e_rpc;
  logic   m_ctr_we;            // Pending writes for the next edge
  logic   m_btb_we;
  idx_t   m_idx;
  ctr_t   m_new_ctr;
  row_t   m_row;

  bp_top dut (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .fetch    (fetch),
    .resolve  (resolve),
    .pred     (pred),
    .redirect (redirect)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;   // 40 ns period

  // Run limit from the table length
  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    grp_checks++;
    if (got !== exp) begin
      $display("** Error at %0t: %s got %0h, expected %0h", $time, what, got, exp);
      fail_count++;
      grp_errs++;
    end else begin
      pass_count++;
    end
  endtask

  // Saturating move toward the resolved direction
  function automatic ctr_t next_counter(ctr_t c, logic taken);
    if (taken) begin
      return (c == ctr_strong_t) ? c : ctr_t'(c + 2'd1);
    end
    return (c == ctr_strong_nt) ? c : ctr_t'(c - 2'd1);
  endfunction

  task automatic add_row(input int g, input bit fv, input pc_t fpc, input bit wb,
                         input bit tk, input pc_t rtgt, input bit st, input int ectr,
                         input pc_t etgt, input bit erv, input pc_t erpc);
    row_t r;
    r.grp     = 3'(g);
    r.fetch   = '{valid: fv, pc: fpc};
    r.res     = '{was_branch: wb, actual_taken: tk, actual_target: rtgt};
    r.stall   = st;
    r.exp_ctr = ctr_t'(ectr);
    r.exp_tgt = etgt;
    r.exp_rv  = erv;
    r.exp_rpc = erpc;
    rows.push_back(r);
  endtask

  // Model outputs for the current inputs with writes held for the edge
  task automatic predict_outputs(input row_t r);
    idx_t fi;
    logic honored;
    logic guess;
    logic dmis;
    logic tmis;
    fi       = r.fetch.pc[`BP_IDX_W:1];
    e_ctr    = m_ctr[fi];
    e_tgt    = m_tgt[fi];
    honored  = m_if_id.valid && !r.stall && r.res.was_branch;
    guess    = (m_if_id.pred.ctr == ctr_weak_t) || (m_if_id.pred.ctr == ctr_strong_t);
    dmis     = guess != r.res.actual_taken;
    tmis     = r.res.actual_taken && (m_if_id.pred.target != r.res.actual_target);
    e_rv     = honored && (dmis || (tmis && guess));
    e_rpc    = r.res.actual_taken ? r.res.actual_target
                                  : m_if_id.pc + pc_t'(`BP_INSN_BYTES);
    m_ctr_we  = honored;
    m_btb_we  = honored && tmis;
    m_idx     = m_if_id.pc[`BP_IDX_W:1];
    m_new_ctr = next_counter(m_if_id.pred.ctr, r.res.actual_taken);
    m_row     = r;
  endtask

  // Clock edge of the model
  task automatic advance_model();
    if (m_ctr_we) m_ctr[m_idx] = m_new_ctr;
    if (m_btb_we) m_tgt[m_idx] = m_row.res.actual_target;
    if (!m_row.stall) begin                       // Stall holds IF/ID
      m_if_id.valid = m_row.fetch.valid && !e_rv; // Squashed by redirect
      m_if_id.pc    = m_row.fetch.pc;
      m_if_id.pred  = '{ctr: e_ctr, target: e_tgt};
    end
  endtask

  function automatic row_t random_row();
    row_t r;
    r = '0;
    r.grp                  = 3'd6;
    r.fetch.valid          = ({$random(seed)} % 10) != 0;
    r.fetch.pc             = pc_t'($random(seed)) & 16'h00fe;   // Even PCs with aliasing
    r.res.was_branch       = ({$random(seed)} % 10) < 6;
    r.res.actual_taken     = ({$random(seed)} % 2) == 1;
    r.res.actual_target    = pc_t'(({$random(seed)} % 4) * 64);  // Few even targets
    r.stall                = ({$random(seed)} % 8) == 0;
    return r;
  endfunction

  // Drive 2 ns after the edge and check at the falling edge
  task automatic apply_row(input int n, input row_t r, input bit use_model);
    ctr_t  x_ctr;
    pc_t   x_tgt;
    logic  x_rv;
    pc_t   x_rpc;
    string tag;
    #2;
    rst     = 1'b0;   // Released with the first row
    fetch   = r.fetch;
    resolve = r.res;
    stall   = r.stall;
    predict_outputs(r);
    x_ctr = use_model ? e_ctr : r.exp_ctr;
    x_tgt = use_model ? e_tgt : r.exp_tgt;
    x_rv  = use_model ? e_rv  : r.exp_rv;
    x_rpc = use_model ? e_rpc : r.exp_rpc;
    @(negedge clk);
    tag = $sformatf("row %0d", n);
    check_equal({tag, " pred ctr"}, 32'(pred.ctr), 32'(x_ctr));
    check_equal({tag, " pred target"}, 32'(pred.target), 32'(x_tgt));
    check_equal({tag, " redirect valid"}, 32'(redirect.valid), 32'(x_rv));
    if (x_rv) check_equal({tag, " redirect pc"}, 32'(redirect.pc), 32'(x_rpc));
    advance_model();
    @(posedge clk);
  endtask

  task automatic report_behavior(input int g);
    $display("Behavior %0d, %s: %0d checks, %0d errors", g, grp_name[g], grp_checks,
             grp_errs);
    grp_checks = 0;
    grp_errs   = 0;
  endtask

  ////////////////////////////////////////
  // Directed table
  ////////////////////////////////////////

  task automatic build_table();
    for (int i = 0; i < `BP_DEPTH; i++) begin
      add_row(1, 1, pc_t'(i * 2), 0, 0, 16'h0, 0, 0, 16'h0, 0, 16'h0);   // Reset scan
    end
    // grp fv pc  wb tk target st | ctr target rv rpc
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 0, 16'h0, 0, 16'h0);
    add_row(2, 0, PC_A, 1, 1, T1,    0, 0, 16'h0, 1, T1);       // Cold miss fills the BTB
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 1, T1,    0, 16'h0);
    add_row(2, 0, PC_A, 1, 1, T1,    0, 1, T1,    1, T1);       // Still guessed not taken
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 2, T1,    0, 16'h0);
    add_row(2, 0, PC_A, 1, 1, T1,    0, 2, T1,    0, 16'h0);
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 3, T1,    0, 16'h0);
    add_row(2, 0, PC_A, 1, 1, T1,    0, 3, T1,    0, 16'h0);
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 3, T1,    0, 16'h0);    // Saturated high
    add_row(2, 0, PC_A, 1, 0, 16'h0, 0, 3, T1,    1, 16'h0012);
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 2, T1,    0, 16'h0);
    add_row(2, 0, PC_A, 1, 0, 16'h0, 0, 2, T1,    1, 16'h0012);
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 1, T1,    0, 16'h0);
    add_row(2, 0, PC_A, 1, 0, 16'h0, 0, 1, T1,    0, 16'h0);
    add_row(2, 1, PC_A, 0, 0, 16'h0, 0, 0, T1,    0, 16'h0);
    add_row(2, 0, PC_A, 1, 0, 16'h0, 0, 0, T1,    0, 16'h0);
    add_row(2, 0, PC_A, 0, 0, 16'h0, 0, 0, T1,    0, 16'h0);    // Saturated low
    add_row(3, 1, PC_B, 0, 0, 16'h0, 0, 0, 16'h0, 0, 16'h0);
    add_row(3, 0, PC_B, 1, 1, T2,    0, 0, 16'h0, 1, T2);
    add_row(3, 1, PC_B, 0, 0, 16'h0, 0, 1, T2,    0, 16'h0);    // Stored target seen
    add_row(3, 0, PC_B, 1, 1, T2,    0, 1, T2,    1, T2);
    add_row(3, 1, PC_B, 0, 0, 16'h0, 0, 2, T2,    0, 16'h0);
    add_row(3, 0, PC_B, 1, 1, T3,    0, 2, T2,    1, T3);       // Target redirect
    add_row(3, 1, PC_B, 0, 0, 16'h0, 0, 3, T3,    0, 16'h0);
    add_row(3, 0, PC_B, 1, 1, T3,    0, 3, T3,    0, 16'h0);
    add_row(4, 1, PC_B, 0, 0, 16'h0, 0, 3, T3,    0, 16'h0);
    add_row(4, 1, PC_A, 1, 0, 16'h0, 0, 0, T1,    1, 16'h0026); // Fetch of A squashed
    add_row(4, 1, PC_B, 1, 1, 16'h0300, 0, 2, T3, 0, 16'h0);    // Bubble ignored
    add_row(4, 1, PC_A, 0, 0, 16'h0, 0, 0, T1,    0, 16'h0);    // A untouched
    add_row(5, 1, PC_B, 1, 1, T1,    1, 2, T3,    0, 16'h0);    // IF/ID holds A
    add_row(5, 1, PC_B, 1, 1, T1,    1, 2, T3,    0, 16'h0);    // Fetch of B not captured
    add_row(5, 0, PC_A, 1, 1, T1,    0, 0, T1,    1, T1);       // Resolves after stall
    add_row(5, 1, PC_A, 0, 0, 16'h0, 0, 1, T1,    0, 16'h0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    stall      = 1'b0;
    fetch      = '0;
    resolve    = '0;
    cycles     = 0;
    pass_count = 0;
    fail_count = 0;
    grp_checks = 0;
    grp_errs   = 0;
    grp_name[1] = "reset state";
    grp_name[2] = "counter training";
    grp_name[3] = "target buffer";
    grp_name[4] = "redirect and flush";
    grp_name[5] = "stall";
    grp_name[6] = "random stream";
    build_table();
    cycle_limit = 16 + rows.size() + N_RANDOM + 50;
    for (int i = 0; i < `BP_DEPTH; i++) begin
      m_ctr[i] = ctr_strong_nt;   // Model matches reset contents
      m_tgt[i] = '0;
    end
    m_if_id  = '0;
    repeat (16) @(posedge clk);
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(i, rows[i], 1'b0);
      if (i == rows.size() - 1 || rows[i + 1].grp != rows[i].grp) begin
        report_behavior(int'(rows[i].grp));
      end
    end
    for (int i = 0; i < N_RANDOM; i++) begin
      apply_row(rows.size() + i, random_row(), 1'b1);
    end
    report_behavior(6);
    $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== hdl/bp_consts.svh ====
/*
 * Sizing macros for the branch prediction slice
 * PC width, table index width, table depth, instruction size
 */
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Width of a fetch PC and of a branch target
`define BP_PC_W 16

// Table index, taken from PC bits BP_IDX_W down to 1
`define BP_IDX_W 4

// Entries per table, one per index value
`define BP_DEPTH 16

// Halfword instructions, fall-through step in bytes
`define BP_INSN_BYTES 2

`endif

// ==== hdl/bp_pkg.sv ====
/*
 * Shared types of the branch prediction slice
 * Address, index and counter types, pipeline structs, counter step function
 */
`include "bp_consts.svh"

package bp_pkg;

  typedef logic [`BP_PC_W-1:0]  pc_t;   // Fetch address or target
  typedef logic [`BP_IDX_W-1:0] idx_t;  // Table index

  // 2-bit saturating counter, MSB is the taken guess
  typedef enum logic [1:0] {
    ctr_strong_nt = 2'b00,
    ctr_weak_nt   = 2'b01,
    ctr_weak_t    = 2'b10,
    ctr_strong_t  = 2'b11
  } ctr_t;

  typedef struct packed {
    logic valid;                 // Fetch slot holds an instruction
    pc_t  pc;
  } fetch_req_t;

  typedef struct packed {
    ctr_t ctr;                   // Counter read at fetch
    pc_t  target;                // BTB target read at fetch
  } pred_t;

  typedef struct packed {
    logic  valid;
    pc_t   pc;
    pred_t pred;
  } if_id_t;

  typedef struct packed {
    logic was_branch;            // Decode found a branch
    logic actual_taken;
    pc_t  actual_target;
  } resolve_t;

  typedef struct packed {
    logic ctr_we;                // Counter table write
    logic btb_we;                // Target buffer write
    idx_t idx;
    ctr_t ctr;
    pc_t  target;
  } train_t;

  typedef struct packed {
    logic valid;
    pc_t  pc;                    // Corrected fetch address
  } redirect_t;

  // One saturating step toward the resolved direction
  function automatic ctr_t ctr_step(ctr_t cur, logic taken);
    ctr_t nxt;
    unique case (cur)
      ctr_strong_nt: nxt = taken ? ctr_weak_nt  : ctr_strong_nt;
      ctr_weak_nt:   nxt = taken ? ctr_weak_t   : ctr_strong_nt;
      ctr_weak_t:    nxt = taken ? ctr_strong_t : ctr_weak_nt;
      default:       nxt = taken ? ctr_strong_t : ctr_weak_t;  // Strong taken
    endcase
    return nxt;
  endfunction

endpackage

// ==== hdl/bp_top.sv ====
/*
 * Branch prediction slice top level
 * Predictor, IF/ID register and decode resolver
 */
module bp_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall,
  input  bp_pkg::fetch_req_t fetch,
  input  bp_pkg::resolve_t   resolve,   // Outcome for the IF/ID entry
  output bp_pkg::pred_t      pred,
  output bp_pkg::redirect_t  redirect
);

  import bp_pkg::*;

  if_id_t if_id;   // Decode-side entry
  train_t train;   // Resolver back to tables

  dynamic_branch_predictor u_dbp (
    .clk   (clk),
    .rst   (rst),
    .fetch (fetch),
    .pred  (pred),
    .train (train)
  );

  // Redirect squashes the fetch of the same cycle
  if_id_stage u_if_id (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .flush (redirect.valid),
    .fetch (fetch),
    .pred  (pred),
    .if_id (if_id)
  );

  branch_resolver u_resolver (
    .if_id    (if_id),
    .resolve  (resolve),
    .stall    (stall),
    .train    (train),
    .redirect (redirect)
  );

  ////////////////////////////////////////
  // Resolver checks
  ////////////////////////////////////////

  // A squashed slot must never steer fetch
  a_redirect_needs_valid : assert property (
    @(posedge clk) disable iff (rst) redirect.valid |-> if_id.valid
  ) else $error("redirect from an empty IF/ID slot");

  // Tables stay frozen while decode is stalled
  a_no_train_in_stall : assert property (
    @(posedge clk) disable iff (rst) stall |-> !(train.ctr_we || train.btb_we)
  ) else $error("table training during stall");

endmodule

// ==== hdl/branch_resolver.sv ====
/*
 * Decode-side branch resolver
 * Direction and target mismatch, table training, redirect
 */
`include "bp_consts.svh"

module branch_resolver (
  input  bp_pkg::if_id_t    if_id,     // Instruction now in decode
  input  bp_pkg::resolve_t  resolve,   // Outcome from decode
  input  logic              stall,
  output bp_pkg::train_t    train,     // Table writes, next edge
  output bp_pkg::redirect_t redirect   // Corrected fetch PC
);

  import bp_pkg::*;

  logic honored;      // Valid branch, not stalled
  logic guess_taken;  // Direction predicted at fetch
  logic dir_mis;      // Direction mismatch
  logic tgt_mis;      // Taken, but BTB target wrong
  pc_t  fall_pc;      // Next sequential address

  ////////////////////////////////////////
  // Compare guess with outcome
  ////////////////////////////////////////

  // Stall keeps this entry for another try
  assign honored     = if_id.valid & ~stall & resolve.was_branch;
  assign guess_taken = if_id.pred.ctr[1];
  assign dir_mis     = guess_taken != resolve.actual_taken;
  assign tgt_mis     = resolve.actual_taken &
                       (if_id.pred.target != resolve.actual_target);
  assign fall_pc     = if_id.pc + pc_t'(`BP_INSN_BYTES);

  ////////////////////////////////////////
  // Training
  ////////////////////////////////////////

  always_comb begin
    train.ctr_we = honored;              // Counter trains on every branch
    train.btb_we = honored & tgt_mis;    // Target only when wrong
    train.idx    = if_id.pc[`BP_IDX_W:1];
    // Step from the counter seen at fetch
    train.ctr    = ctr_step(if_id.pred.ctr, resolve.actual_taken);
    train.target = resolve.actual_target;
  end

  ////////////////////////////////////////
  // Redirect
  ////////////////////////////////////////

  // Bad target only matters if fetch followed it
  always_comb begin
    redirect.valid = honored & (dir_mis | (tgt_mis & guess_taken));
    redirect.pc    = resolve.actual_taken ? resolve.actual_target
                                          : fall_pc;   // Taken guess was wrong
  end

endmodule

// ==== hdl/dynamic_branch_predictor.sv ====
/*
 * Fetch-side dynamic branch predictor
 * Counter table (BHT) and target buffer (BTB), prediction read,
 * write port driven by the decode-side training request
 */
`include "bp_consts.svh"

module dynamic_branch_predictor (
  input  logic               clk,
  input  logic               rst,
  input  bp_pkg::fetch_req_t fetch,   // Current fetch PC
  output bp_pkg::pred_t      pred,    // Guess for fetch.pc, same cycle
  input  bp_pkg::train_t     train    // Update from the resolver
);

  import bp_pkg::*;

  idx_t fetch_idx;   // Read index for both tables
  ctr_t bht_rd;      // Counter for fetch PC
  pc_t  btb_rd;      // Stored target for fetch PC

  ////////////////////////////////////////
  // Index
  ////////////////////////////////////////

  // Bit 0 is always zero for halfword fetch, skip it
  assign fetch_idx = fetch.pc[`BP_IDX_W:1];

  ////////////////////////////////////////
  // Counter table
  ////////////////////////////////////////

  // Resets to strong not taken, encoding 0
  // Counter step already applied by the resolver
  pred_table #(
    .entry_t (ctr_t),
    .DEPTH   (`BP_DEPTH)
  ) u_bht (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (fetch_idx),
    .rd_data (bht_rd),
    .we      (train.ctr_we),
    .wr_idx  (train.idx),
    .wr_data (train.ctr)
  );

  ////////////////////////////////////////
  // Branch target buffer
  ////////////////////////////////////////

  // Targets reset to 0, written only on a target mismatch
  pred_table #(
    .entry_t (pc_t),
    .DEPTH   (`BP_DEPTH)
  ) u_btb (
    .clk     (clk),
    .rst     (rst),
    .rd_idx  (fetch_idx),
    .rd_data (btb_rd),
    .we      (train.btb_we),
    .wr_idx  (train.idx),
    .wr_data (train.target)
  );

  ////////////////////////////////////////
  // Prediction out
  ////////////////////////////////////////

  // No bypass, a same-cycle write is seen on the next fetch
  always_comb begin
    pred.ctr    = bht_rd;   // Taken guess is ctr[1]
    pred.target = btb_rd;
  end

  // Decode only hands back halfword-aligned targets
  a_btb_even : assert property (
    @(posedge clk) disable iff (rst) train.btb_we |-> !train.target[0]
  ) else $error("BTB write with odd target");

endmodule

// ==== hdl/if_id_stage.sv ====
/*
 * IF/ID pipeline register
 * Fetch PC and its prediction, with stall hold and flush
 */
module if_id_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               stall,   // Hold current entry
  input  logic               flush,   // Squash the fetch at this edge
  input  bp_pkg::fetch_req_t fetch,
  input  bp_pkg::pred_t      pred,
  output bp_pkg::if_id_t     if_id
);

  import bp_pkg::*;

  logic  valid_q;   // Entry is live
  pc_t   pc_q;
  pred_t pred_q;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= fetch.valid & ~flush;   // Flush loads a bubble
    end
  end

  // Captured fetch PC and its prediction
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q   <= fetch.pc;
      pred_q <= pred;
    end
  end

  assign if_id = '{valid: valid_q, pc: pc_q, pred: pred_q};

  // Redirect is blocked upstream while stalled
  // A flush under stall would be dropped by the hold
  a_no_flush_in_stall : assert property (
    @(posedge clk) disable iff (rst) flush |-> !stall
  ) else $error("IF/ID flush during stall");

endmodule

// ==== hdl/pred_table.sv ====
/*
 * Generic prediction table, register array
 * One asynchronous read port, one synchronous write port
 */
`include "bp_consts.svh"

module pred_table #(
  parameter type entry_t = logic,      // Stored payload type
  parameter int  DEPTH   = `BP_DEPTH   // Number of entries
) (
  input  logic         clk,
  input  logic         rst,
  input  bp_pkg::idx_t rd_idx,   // Fetch-side index
  output entry_t       rd_data,
  input  logic         we,
  input  bp_pkg::idx_t wr_idx,   // Resolve-side index
  input  entry_t       wr_data
);

  entry_t mem [DEPTH];           // Table storage

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Combinational read, same cycle as fetch
  // A write in this cycle shows up only after the edge
  assign rd_data = mem[rd_idx];

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= entry_t'(0);   // All-zero entry
      end
    end else if (we) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // Write index must be resolved whenever a write fires
  a_wr_idx_known : assert property (
    @(posedge clk) disable iff (rst) we |-> !$isunknown(wr_idx)
  ) else $error("pred_table write with unknown index");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the branch prediction testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module bp_tb -f tb.f -o bp_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/bp_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation run exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== tb.f ====
+incdir+hdl
hdl/bp_pkg.sv
hdl/pred_table.sv
hdl/dynamic_branch_predictor.sv
hdl/if_id_stage.sv
hdl/branch_resolver.sv
hdl/bp_top.sv
bench/bp_tb.sv
